//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= conv_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/conv_accel.sv
`timescale 1ns/1ps

module conv_accel (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            hold_i,

   // filter buffer control
   input  logic            filt_ld_one_i,
   input  logic            filt_ld_two_i,
   input  logic            filt_clr_i,

   // data buffer control
   input  logic            data_ld_one_i,
   input  logic            data_ld_two_i,
   input  logic            data_clr_i,

   // register values from the core
   input  conv_pkg::word_t rs1_i,
   input  conv_pkg::word_t rs2_i,

   input  logic            run_i,
   output conv_pkg::word_t result_o,
   output logic            ready_o,
   output logic            stall_o
);

   operand_buf_if filt_bus ();
   operand_buf_if data_bus ();

   // rs1 fills the entry at the pointer, rs2 the one after it
   operand_buffer u_filt_buf (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .hold_i   (hold_i),
      .ld_one_i (filt_ld_one_i),
      .ld_two_i (filt_ld_two_i),
      .word0_i  (rs1_i),
      .word1_i  (rs2_i),
      .clr_i    (filt_clr_i),
      .bus      (filt_bus)
   );

   operand_buffer u_data_buf (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .hold_i   (hold_i),
      .ld_one_i (data_ld_one_i),
      .ld_two_i (data_ld_two_i),
      .word0_i  (rs1_i),
      .word1_i  (rs2_i),
      .clr_i    (data_clr_i),
      .bus      (data_bus)
   );

   mac_sequencer u_mac_seq (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .hold_i   (hold_i),
      .run_i    (run_i),
      .filt     (filt_bus),
      .data     (data_bus),
      .result_o (result_o),
      .ready_o  (ready_o),
      .stall_o  (stall_o)
   );

endmodule

//--- design/conv_pkg.sv
`include "conv_settings.svh"

package conv_pkg;

   typedef logic [`CONV_WORD_W-1:0] word_t;
   typedef logic [`CONV_IDX_W-1:0]  idx_t;
   typedef logic [`CONV_DEPTH-1:0]  mask_t; // one bit per stored entry

   // per-cycle action of an operand buffer
   typedef enum logic [1:0] {
      LOAD_NONE,
      LOAD_ONE,
      LOAD_TWO
   } load_mode_e;

   typedef enum logic {
      SEQ_ACCUM, // pairs still to consume
      SEQ_DONE   // all pairs consumed, waits for a clear
   } seq_state_e;

endpackage

//--- design/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// operand and result width, products wrap to this
`define CONV_WORD_W 32

// entries in each operand buffer
`define CONV_DEPTH 16

// bits needed to address one entry
`define CONV_IDX_W 4

`endif

//--- design/mac_sequencer.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module mac_sequencer (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            hold_i,
   input  logic            run_i,
   operand_buf_if.seq_mp   filt,
   operand_buf_if.seq_mp   data,
   output conv_pkg::word_t result_o,
   output logic            ready_o,
   output logic            stall_o
);
   import conv_pkg::*;

   localparam idx_t LAST_IDX = idx_t'(`CONV_DEPTH - 1);

   seq_state_e state_q;
   seq_state_e state_n;
   idx_t       idx_q;
   idx_t       idx_n;
   word_t      acc_q;
   word_t      acc_n;
   word_t      product;
   logic       pair_ok;
   logic       restart;
   logic       consume;
   logic       caught_up;

   // both buffers read at the same pair index
   assign filt.rd_idx = idx_q;
   assign data.rd_idx = idx_q;

   assign pair_ok = filt.valid[idx_q] & data.valid[idx_q];
   assign restart = filt.cleared | data.cleared;
   assign consume = (state_q == SEQ_ACCUM) && pair_ok;

   // unsigned, upper half of the full product is dropped
   assign product = filt.rd_word * data.rd_word;

   always_comb begin
      state_n = state_q;
      idx_n   = idx_q;
      acc_n   = acc_q;
      if (restart) begin
         state_n = SEQ_ACCUM;
         idx_n   = '0;
         acc_n   = '0;
      end else if (consume) begin
         acc_n = acc_q + product;
         if (idx_q == LAST_IDX) begin
            state_n = SEQ_DONE; // idx stays on the last entry
         end else begin
            idx_n = idx_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= SEQ_ACCUM;
         idx_q   <= '0;
         acc_q   <= '0;
      end else if (!hold_i) begin
         state_q <= state_n;
         idx_q   <= idx_n;
         acc_q   <= acc_n;
      end
   end

   // nothing left that could change the sum right now
   always_comb begin
      unique case (state_q)
         SEQ_ACCUM: caught_up = ~pair_ok;
         SEQ_DONE:  caught_up = 1'b1;
         default:   caught_up = 1'b1;
      endcase
   end

   assign ready_o  = run_i & caught_up & ~hold_i;
   assign stall_o  = run_i & ~caught_up & ~hold_i; // core keeps run_i up meanwhile
   assign result_o = acc_q;

endmodule

//--- design/operand_buf_if.sv
`timescale 1ns/1ps

interface operand_buf_if;
   import conv_pkg::*;

   mask_t valid;   // bit k set once entry k is stored
   idx_t  rd_idx;  // entry the sequencer wants
   word_t rd_word; // word at rd_idx, no read latency
   logic  cleared; // one cycle after a clear

   modport buf_mp (
      output valid,
      output rd_word,
      output cleared,
      input  rd_idx
   );

   modport seq_mp (
      output rd_idx,
      input  valid,
      input  rd_word,
      input  cleared
   );

endinterface

//--- design/operand_buffer.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module operand_buffer (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            hold_i,
   input  logic            ld_one_i,
   input  logic            ld_two_i,
   input  conv_pkg::word_t word0_i,
   input  conv_pkg::word_t word1_i,
   input  logic            clr_i,
   operand_buf_if.buf_mp   bus
);
   import conv_pkg::*;

   localparam int unsigned DEPTH = `CONV_DEPTH;

   word_t                mem [DEPTH];
   logic [`CONV_IDX_W:0] wr_ptr;    // extra bit, 16 means full
   logic [`CONV_IDX_W:0] wr_ptr_p1;
   logic [`CONV_IDX_W:0] ptr_next;
   mask_t                valid_q;
   logic                 cleared_q;
   load_mode_e           mode;
   logic                 wr0_ok;
   logic                 wr1_ok;
   idx_t                 wr_idx0;
   idx_t                 wr_idx1;

   // two-word strobe wins, clear and hold suppress any load
   always_comb begin
      if (hold_i || clr_i) begin
         mode = LOAD_NONE;
      end else if (ld_two_i) begin
         mode = LOAD_TWO;
      end else if (ld_one_i) begin
         mode = LOAD_ONE;
      end else begin
         mode = LOAD_NONE;
      end
   end

   assign wr_ptr_p1 = wr_ptr + 1'b1;
   assign wr_idx0   = wr_ptr[`CONV_IDX_W-1:0];
   assign wr_idx1   = wr_ptr_p1[`CONV_IDX_W-1:0];

   // writes past the last entry are dropped
   assign wr0_ok = (mode != LOAD_NONE) && (wr_ptr < DEPTH);
   assign wr1_ok = (mode == LOAD_TWO) && (wr_ptr_p1 < DEPTH);

   always_comb begin
      ptr_next = wr_ptr;
      if (wr1_ok) begin
         ptr_next = wr_ptr_p1 + 1'b1;
      end else if (wr0_ok) begin
         ptr_next = wr_ptr_p1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_ptr    <= '0;
         valid_q   <= '0;
         cleared_q <= 1'b0;
      end else if (!hold_i) begin
         cleared_q <= clr_i; // pulse lasts one active cycle
         if (clr_i) begin
            wr_ptr  <= '0;
            valid_q <= '0;
         end else begin
            wr_ptr <= ptr_next;
            if (wr0_ok) begin
               valid_q[wr_idx0] <= 1'b1;
            end
            if (wr1_ok) begin
               valid_q[wr_idx1] <= 1'b1;
            end
         end
      end
   end

   // storage only, valid_q tells which entries mean anything
   always_ff @(posedge clk_i) begin
      if (wr0_ok) begin
         mem[wr_idx0] <= word0_i;
      end
      if (wr1_ok) begin
         mem[wr_idx1] <= word1_i;
      end
   end

   assign bus.valid   = valid_q;
   assign bus.rd_word = mem[bus.rd_idx];
   assign bus.cleared = cleared_q;

endmodule

//--- sources.f
+incdir+design
design/conv_pkg.sv
design/operand_buf_if.sv
design/operand_buffer.sv
design/mac_sequencer.sv
design/conv_accel.sv
verif/conv_tb_clock.sv
verif/conv_tb_checker.sv
verif/conv_tb.sv

//--- verif/conv_tb.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_tb;
   import conv_pkg::*;

   localparam int NUM_TESTS       = 6;
   localparam int RUN_LIMIT       = 40; // cycles from run_i to ready_o
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 64 + 200;
   localparam int DEPTH           = `CONV_DEPTH;

   logic  clk_i;
   logic  rst_i;
   logic  hold_i;
   logic  filt_ld_one_i;
   logic  filt_ld_two_i;
   logic  filt_clr_i;
   logic  data_ld_one_i;
   logic  data_ld_two_i;
   logic  data_clr_i;
   word_t rs1_i;
   word_t rs2_i;
   logic  run_i;
   word_t result_o;
   logic  ready_o;
   logic  stall_o;

   int    seed = 32'hc7b;
   int    errors;
   int    checks;
   word_t model_mem [2][DEPTH]; // index 0 filter, 1 data
   int    model_cnt [2];
   word_t exp_result;
   bit    got_ready;
   bit    stall_seen;

   conv_tb_clock #(.PERIOD_NS(20)) u_clock (.clk_o(clk_i));

   conv_accel dut (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .filt_ld_one_i (filt_ld_one_i),
      .filt_ld_two_i (filt_ld_two_i),
      .filt_clr_i    (filt_clr_i),
      .data_ld_one_i (data_ld_one_i),
      .data_ld_two_i (data_ld_two_i),
      .data_clr_i    (data_clr_i),
      .rs1_i         (rs1_i),
      .rs2_i         (rs2_i),
      .run_i         (run_i),
      .result_o      (result_o),
      .ready_o       (ready_o),
      .stall_o       (stall_o)
   );

   // dot product of the first n pairs, wraps at 2^32
   function automatic word_t ref_dot(input int n);
      word_t acc;
      acc = '0;
      for (int k = 0; k < n; k++) begin
         acc = acc + word_t'(model_mem[0][k] * model_mem[1][k]);
      end
      return acc;
   endfunction

   function automatic int paired_count();
      return (model_cnt[0] < model_cnt[1]) ? model_cnt[0] : model_cnt[1];
   endfunction

   task automatic check_word(input string name, input word_t actual, input word_t expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %0t ns %s: expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input bit actual, input bit expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %0t ns %s: expected %0b, got %0b", $time, name, expected, actual);
      end
   endtask

   // clear wins, words past the last entry are dropped
   task automatic model_load(input int b, input load_mode_e m, input bit clr,
                             input word_t w0, input word_t w1);
      if (clr) begin
         model_cnt[b] = 0;
      end else if (m != LOAD_NONE) begin
         if (model_cnt[b] < DEPTH) begin
            model_mem[b][model_cnt[b]] = w0;
            model_cnt[b]++;
         end
         if (m == LOAD_TWO && model_cnt[b] < DEPTH) begin
            model_mem[b][model_cnt[b]] = w1;
            model_cnt[b]++;
         end
      end
   endtask

   task automatic drive_cycle(input load_mode_e fm, input load_mode_e dm, input bit fclr,
                              input bit dclr, input bit hold, input bit run);
      word_t w0;
      word_t w1;
      w0 = $random(seed);
      w1 = $random(seed);
      @(posedge clk_i);
      filt_ld_one_i <= (fm == LOAD_ONE);
      filt_ld_two_i <= (fm == LOAD_TWO);
      filt_clr_i    <= fclr;
      data_ld_one_i <= (dm == LOAD_ONE);
      data_ld_two_i <= (dm == LOAD_TWO);
      data_clr_i    <= dclr;
      rs1_i         <= w0;
      rs2_i         <= w1;
      hold_i        <= hold;
      run_i         <= run;
      if (!hold) begin
         model_load(0, fm, fclr, w0, w1);
         model_load(1, dm, dclr, w0, w1);
      end
   endtask

   task automatic clear_strobes();
      filt_ld_one_i <= 1'b0;
      filt_ld_two_i <= 1'b0;
      filt_clr_i    <= 1'b0;
      data_ld_one_i <= 1'b0;
      data_ld_two_i <= 1'b0;
      data_clr_i    <= 1'b0;
   endtask

   // fills buffer b up to target words with a random mix of strobes
   task automatic load_words(input int b, input int target, input bit hold_mix,
                             input bit run_last);
      load_mode_e m;
      bit         hold;
      bit         clr;
      bit         run;
      int         left;
      while (model_cnt[b] < target) begin
         left = target - model_cnt[b];
         m    = (left >= 2 && ($random(seed) & 1) != 0) ? LOAD_TWO : LOAD_ONE;
         hold = hold_mix && (($random(seed) & 3) == 0);
         clr  = hold && (($random(seed) & 1) != 0); // ignored under hold
         run  = run_last && !hold && (left <= ((m == LOAD_TWO) ? 2 : 1));
         if (b == 0) begin
            drive_cycle(m, LOAD_NONE, clr, 1'b0, hold, run);
         end else begin
            drive_cycle(LOAD_NONE, m, 1'b0, clr, hold, run);
         end
      end
      if (!run_last) begin
         drive_cycle(LOAD_NONE, LOAD_NONE, 1'b0, 1'b0, 1'b0, 1'b0);
      end
   endtask

   task automatic expect_now();
      exp_result = ref_dot(paired_count());
      got_ready  = 1'b0;
      stall_seen = 1'b0;
   endtask

   task automatic wait_ready(input int hold_cycles);
      int cycles;
      cycles = 0;
      while (!got_ready && cycles < RUN_LIMIT) begin
         @(posedge clk_i);
         cycles++;
         clear_strobes();
         hold_i <= (cycles < hold_cycles);
      end
      if (!got_ready) begin
         errors++;
         $display("ERROR at %0t ns: no ready_o within %0d cycles of run_i", $time, RUN_LIMIT);
      end
      run_i  <= 1'b0;
      hold_i <= 1'b0;
   endtask

   task automatic start_run(input int hold_cycles);
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b0, 1'b0, hold_cycles > 0, 1'b1);
      expect_now();
      wait_ready(hold_cycles);
   endtask

   // compares in mid-cycle while run_i is held
   always @(negedge clk_i) begin
      if (!rst_i || hold_i || !run_i) begin
         check_flag("ready_o", ready_o, 1'b0);
         check_flag("stall_o", stall_o, 1'b0);
      end else if (ready_o) begin
         check_flag("stall_o", stall_o, 1'b0);
         check_word("result_o", result_o, exp_result);
         got_ready = 1'b1;
      end else begin
         check_flag("stall_o", stall_o, 1'b1); // not caught up yet
         stall_seen = 1'b1;
      end
   end

   // limit scales with the number of tests
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("ERROR: watchdog expired after %0d cycles, tests did not complete",
               WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      word_t       step_res;
      int unsigned asrt_fails;
      errors        = 0;
      checks        = 0;
      model_cnt     = '{0, 0};
      exp_result    = '0;
      got_ready     = 1'b0;
      stall_seen    = 1'b0;
      rst_i         = 1'b0;
      hold_i        = 1'b0;
      filt_ld_one_i = 1'b0;
      filt_ld_two_i = 1'b0;
      filt_clr_i    = 1'b0;
      data_ld_one_i = 1'b0;
      data_ld_two_i = 1'b0;
      data_clr_i    = 1'b0;
      rs1_i         = '0;
      rs2_i         = '0;
      run_i         = 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b1;

      // full run
      load_words(0, DEPTH, 1'b0, 1'b0);
      load_words(1, DEPTH, 1'b0, 1'b0);
      start_run(0);

      // partial run, then one more filter word
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b1, 1'b1, 1'b0, 1'b0);
      load_words(0, 5, 1'b0, 1'b0);
      load_words(1, 9, 1'b0, 1'b0);
      start_run(0);
      step_res = result_o;
      load_words(0, 6, 1'b0, 1'b0);
      start_run(0);
      check_word("result_o step", result_o - step_res,
                 word_t'(model_mem[0][5] * model_mem[1][5]));

      // run raised with the last data load
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b1, 1'b1, 1'b0, 1'b0);
      load_words(0, DEPTH, 1'b0, 1'b0);
      load_words(1, DEPTH, 1'b0, 1'b1);
      expect_now();
      wait_ready(0);
      check_flag("stall_o seen before ready_o", stall_seen, 1'b1);

      // data cleared mid-stream, filter kept
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b0, 1'b1, 1'b0, 1'b0);
      load_words(1, 6, 1'b0, 1'b0);
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b0, 1'b1, 1'b0, 1'b0);
      load_words(1, 10, 1'b0, 1'b0);
      start_run(0);

      // hold during loads and during run
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b1, 1'b1, 1'b0, 1'b0);
      load_words(0, 12, 1'b1, 1'b0);
      load_words(1, 12, 1'b1, 1'b0);
      start_run(3);

      // overflow, two-word load with 15 stored then more loads
      // filter overflows before any pair is consumed
      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b1, 1'b1, 1'b0, 1'b0);
      load_words(0, DEPTH - 1, 1'b0, 1'b0);
      drive_cycle(LOAD_TWO, LOAD_NONE, 1'b0, 1'b0, 1'b0, 1'b0);
      drive_cycle(LOAD_TWO, LOAD_NONE, 1'b0, 1'b0, 1'b0, 1'b0);
      drive_cycle(LOAD_ONE, LOAD_NONE, 1'b0, 1'b0, 1'b0, 1'b0);
      load_words(1, DEPTH, 1'b0, 1'b0);
      start_run(0);

      drive_cycle(LOAD_NONE, LOAD_NONE, 1'b0, 1'b0, 1'b0, 1'b0);
      repeat (2) @(posedge clk_i);
      asrt_fails = dut.u_chk.fail_cnt;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- verif/conv_tb_checker.sv
`timescale 1ns/1ps

module conv_tb_checker (
   input logic clk_i,
   input logic rst_i,
   input logic hold_i,
   input logic run_i,
   input logic ready_i,
   input logic stall_i
);

   int unsigned fail_cnt = 0; // summed into the closing line

   // sampled mid-cycle, host inputs are settled by then
   a_not_both: assert property (@(negedge clk_i) !(ready_i && stall_i))
      else begin
         fail_cnt++;
         $error("ready and stall high in the same cycle");
      end

   a_needs_run: assert property (@(negedge clk_i) (ready_i || stall_i) |-> run_i)
      else begin
         fail_cnt++;
         $error("ready or stall high without run");
      end

   a_hold_quiet: assert property (@(negedge clk_i) hold_i |-> (!ready_i && !stall_i))
      else begin
         fail_cnt++;
         $error("ready or stall high while hold is set");
      end

endmodule

bind conv_accel conv_tb_checker u_chk (
   .clk_i   (clk_i),
   .rst_i   (rst_i),
   .hold_i  (hold_i),
   .run_i   (run_i),
   .ready_i (ready_o),
   .stall_i (stall_o)
);

//--- verif/conv_tb_clock.sv
`timescale 1ns/1ps

module conv_tb_clock #(
   parameter int unsigned PERIOD_NS = 20
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule
